// ==== Makefile ====
# Verilator build and run for the execute unit testbench

TOP = alu_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== src/alu_adder.sv ====
//####################################################################
// combinational, sum is zero unless the op is an add or subtract form
// flags are valid for the compare and min/max opcodes
//####################################################################
`timescale 1ns/100ps

module alu_adder
(
   input  alu_pkg::alu_req_t   req,
   output alu_pkg::alu_data_t  sum,
   output alu_pkg::alu_flags_t flags
);

   alu_pkg::alu_data_t a_scaled;
   alu_pkg::alu_data_t b_mod;
   alu_pkg::alu_data_t raw_sum;
   logic               sub_sel;
   logic               unsigned_sel;
   logic               sum_sel;
   logic               cout;
   logic               ov;
   logic               neg;

   // shift-and-add scaling of operand a
   always_comb
   begin
      case (req.op)
         alu_pkg::SH1ADD: a_scaled = req.a << 1;
         alu_pkg::SH2ADD: a_scaled = req.a << 2;
         alu_pkg::SH3ADD: a_scaled = req.a << 3;
         default:         a_scaled = req.a;
      endcase
   end

   // compares and min/max run through the subtractor
   assign sub_sel = req.op inside {alu_pkg::SUB, alu_pkg::SLT, alu_pkg::SLTU,
                                   alu_pkg::MIN, alu_pkg::MAX, alu_pkg::MINU,
                                   alu_pkg::MAXU};

   assign unsigned_sel = req.op inside {alu_pkg::SLTU, alu_pkg::MINU, alu_pkg::MAXU};

   assign sum_sel = req.op inside {alu_pkg::ADD, alu_pkg::SUB, alu_pkg::SH1ADD,
                                   alu_pkg::SH2ADD, alu_pkg::SH3ADD};

   assign b_mod = sub_sel ? ~req.b : req.b;

   assign {cout, raw_sum} = {1'b0, a_scaled} + {1'b0, b_mod}
                          + (alu_pkg::XLEN+1)'(sub_sel);

   assign neg = raw_sum[alu_pkg::XLEN-1];

   // signed overflow when both inputs agree in sign and the sum does not
   assign ov = (~a_scaled[alu_pkg::XLEN-1] & ~b_mod[alu_pkg::XLEN-1] &  neg) |
               ( a_scaled[alu_pkg::XLEN-1] &  b_mod[alu_pkg::XLEN-1] & ~neg);

   // no carry out of a - b means a < b unsigned
   assign flags = '{lt: unsigned_sel ? ~cout : (neg ^ ov),
                    eq: (req.a == req.b)};

   assign sum = sum_sel ? raw_sum : '0;

endmodule

// ==== src/alu_bitcount.sv ====
//####################################################################
// clz/ctz give 32 for a zero operand, count is zero for other ops
//####################################################################
`timescale 1ns/100ps

module alu_bitcount
(
   input  alu_pkg::alu_req_t          req,
   output logic [alu_pkg::CNT_W-1:0]  count
);

   alu_pkg::alu_data_t          a_rev;
   alu_pkg::alu_data_t          lzd_in;
   logic [alu_pkg::CNT_W-1:0]   lz_count;
   logic [alu_pkg::CNT_W-1:0]   pop_count;

   // bit reverse so ctz can reuse the leading-zero search
   always_comb
   begin
      for (int i = 0; i < alu_pkg::XLEN; i++)
      begin
         a_rev[i] = req.a[alu_pkg::XLEN-1-i];
      end
   end

   assign lzd_in = (req.op == alu_pkg::CTZ) ? a_rev : req.a;

   // the highest set bit wins since the loop runs upward
   always_comb
   begin
      lz_count = alu_pkg::CNT_W'(alu_pkg::XLEN);
      for (int i = 0; i < alu_pkg::XLEN; i++)
      begin
         if (lzd_in[i])
         begin
            lz_count = alu_pkg::CNT_W'(alu_pkg::XLEN - 1 - i);
         end
      end
   end

   always_comb
   begin
      pop_count = '0;
      for (int i = 0; i < alu_pkg::XLEN; i++)
      begin
         pop_count = pop_count + alu_pkg::CNT_W'(req.a[i]);
      end
   end

   always_comb
   begin
      case (req.op)
         alu_pkg::CLZ,
         alu_pkg::CTZ:  count = lz_count;
         alu_pkg::CPOP: count = pop_count;
         default:       count = '0;
      endcase
   end

endmodule

// ==== src/alu_logic.sv ====
//####################################################################
// combinational bitwise unit, zero for non-logic opcodes
//####################################################################
`timescale 1ns/100ps

module alu_logic
(
   input  alu_pkg::alu_req_t  req,
   output alu_pkg::alu_data_t lout
);

   alu_pkg::alu_data_t b_eff;
   logic               inv_sel;

   // andn, orn and xnor use the inverse of b
   assign inv_sel = req.op inside {alu_pkg::ANDN, alu_pkg::ORN, alu_pkg::XNOR};

   assign b_eff = inv_sel ? ~req.b : req.b;

   always_comb
   begin
      case (req.op)
         alu_pkg::AND,
         alu_pkg::ANDN:
            lout = req.a & b_eff;
         alu_pkg::OR,
         alu_pkg::ORN:
            lout = req.a | b_eff;
         alu_pkg::XOR,
         alu_pkg::XNOR:
            lout = req.a ^ b_eff;
         default:
            lout = '0;
      endcase
   end

endmodule

// ==== src/alu_pkg.sv ====
//####################################################################
// fixed 32-bit datapath, the counts, rotates and sign extends need it
// opcode encodings run in declaration order from 0
//####################################################################

package alu_pkg;

   // datapath width and derived field widths
   localparam int XLEN    = 32;
   localparam int SHAMT_W = 5;
   localparam int CNT_W   = 6;

   typedef logic [XLEN-1:0] alu_data_t;

   typedef enum logic [4:0]
   {
      ADD,
      SUB,
      SH1ADD,
      SH2ADD,
      SH3ADD,
      SLT,
      SLTU,
      AND,
      OR,
      XOR,
      ANDN,
      ORN,
      XNOR,
      SLL,
      SRL,
      SRA,
      ROL,
      ROR,
      BEXT,
      CLZ,
      CTZ,
      CPOP,
      MIN,
      MAX,
      MINU,
      MAXU,
      SEXT_B,
      SEXT_H
   } alu_op_e;

   // one request, 69 bits
   typedef struct packed
   {
      alu_op_e   op;
      alu_data_t a;
      alu_data_t b;
   } alu_req_t;

   // compare flags from the adder, lt is signed or unsigned per opcode
   typedef struct packed
   {
      logic lt;
      logic eq;
   } alu_flags_t;

endpackage

// ==== src/alu_result.sv ====
//####################################################################
// result register loads on enable & valid, valid register on enable
// both clear on reset, one cycle from request to result
//####################################################################
`timescale 1ns/100ps

module alu_result
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       enable,
   input  logic                       valid,
   input  alu_pkg::alu_req_t          req,
   input  alu_pkg::alu_data_t         sum,
   input  alu_pkg::alu_data_t         lout,
   input  alu_pkg::alu_data_t         sout,
   input  alu_pkg::alu_flags_t        flags,
   input  logic [alu_pkg::CNT_W-1:0]  count,
   output alu_pkg::alu_data_t         result_ff,
   output logic                       result_valid
);

   alu_pkg::alu_data_t minmax_term;
   alu_pkg::alu_data_t slt_term;
   alu_pkg::alu_data_t sext_term;
   alu_pkg::alu_data_t count_term;
   alu_pkg::alu_data_t result;
   logic               minmax_sel;
   logic               min_sel;
   logic               pick_a;

   assign minmax_sel = req.op inside {alu_pkg::MIN, alu_pkg::MAX,
                                      alu_pkg::MINU, alu_pkg::MAXU};
   assign min_sel    = req.op inside {alu_pkg::MIN, alu_pkg::MINU};

   // min keeps a when a <= b, max keeps a when a >= b
   assign pick_a = min_sel ? (flags.lt | flags.eq) : ~flags.lt;

   always_comb
   begin
      if (!minmax_sel)
      begin
         minmax_term = '0;
      end
      else if (pick_a)
      begin
         minmax_term = req.a;
      end
      else
      begin
         minmax_term = req.b;
      end
   end

   assign slt_term = alu_pkg::XLEN'((req.op inside {alu_pkg::SLT, alu_pkg::SLTU}) & flags.lt);

   always_comb
   begin
      case (req.op)
         alu_pkg::SEXT_B: sext_term = {{(alu_pkg::XLEN-8){req.a[7]}}, req.a[7:0]};
         alu_pkg::SEXT_H: sext_term = {{(alu_pkg::XLEN-16){req.a[15]}}, req.a[15:0]};
         default:         sext_term = '0;
      endcase
   end

   assign count_term = alu_pkg::XLEN'(count);

   // every term is zero unless its opcode is selected
   assign result = sum | lout | sout | count_term | minmax_term | slt_term | sext_term;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         result_ff    <= '0;
         result_valid <= 1'b0;
      end
      else if (enable)
      begin
         result_valid <= valid;
         if (valid)
         begin
            result_ff <= result;
         end
      end
   end

endmodule

// ==== src/alu_shifter.sv ====
//####################################################################
// funnel shifter, only the low SHAMT_W bits of b are used
// bext returns the selected bit of a in bit 0
//####################################################################
`timescale 1ns/100ps

module alu_shifter
(
   input  alu_pkg::alu_req_t  req,
   output alu_pkg::alu_data_t sout
);

   logic [alu_pkg::SHAMT_W-1:0]   shamt;
   logic [alu_pkg::SHAMT_W-1:0]   amount;
   logic [2*alu_pkg::XLEN-2:0]    shift_extend;
   alu_pkg::alu_data_t            shifted;
   alu_pkg::alu_data_t            shift_mask;
   logic                          left_sel;
   logic                          copy_sel;
   logic                          shift_sel;

   assign shamt = req.b[alu_pkg::SHAMT_W-1:0];

   assign left_sel  = req.op inside {alu_pkg::SLL, alu_pkg::ROL};
   assign copy_sel  = req.op inside {alu_pkg::SLL, alu_pkg::ROL, alu_pkg::ROR};
   assign shift_sel = req.op inside {alu_pkg::SLL, alu_pkg::SRL, alu_pkg::SRA,
                                     alu_pkg::ROL, alu_pkg::ROR};

   // left shifts become a right shift by 32 - shamt, taken mod 32
   assign amount = left_sel ? alu_pkg::SHAMT_W'(alu_pkg::XLEN - int'(shamt)) : shamt;

   // upper half of the funnel: sign fill, copy of a, or zero
   always_comb
   begin
      shift_extend[alu_pkg::XLEN-1:0] = req.a;
      if (req.op == alu_pkg::SRA)
      begin
         shift_extend[2*alu_pkg::XLEN-2:alu_pkg::XLEN] = {(alu_pkg::XLEN-1){req.a[alu_pkg::XLEN-1]}};
      end
      else if (copy_sel)
      begin
         shift_extend[2*alu_pkg::XLEN-2:alu_pkg::XLEN] = req.a[alu_pkg::XLEN-2:0];
      end
      else
      begin
         shift_extend[2*alu_pkg::XLEN-2:alu_pkg::XLEN] = '0;
      end
   end

   assign shifted = alu_pkg::XLEN'(shift_extend >> amount);

   // sll wraps a's top bits into the low end, clear them
   assign shift_mask = (req.op == alu_pkg::SLL) ? ('1 << shamt) : '1;

   always_comb
   begin
      if (shift_sel)
      begin
         sout = shifted & shift_mask;
      end
      else if (req.op == alu_pkg::BEXT)
      begin
         sout = alu_pkg::XLEN'(shifted[0]);
      end
      else
      begin
         sout = '0;
      end
   end

endmodule

// ==== src/alu_top.sv ====
//####################################################################
// single-cycle execute unit, request taken on a rising edge with
// enable high, result and result_valid appear one cycle later
//####################################################################
`timescale 1ns/100ps

module alu_top
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               enable,
   input  logic               valid,
   input  alu_pkg::alu_req_t  req,
   output alu_pkg::alu_data_t result_ff,
   output logic               result_valid
);

   alu_pkg::alu_data_t          sum;
   alu_pkg::alu_data_t          lout;
   alu_pkg::alu_data_t          sout;
   alu_pkg::alu_flags_t         flags;
   logic [alu_pkg::CNT_W-1:0]   count;

   alu_adder u_adder
   (
      .req   (req),
      .sum   (sum),
      .flags (flags)
   );

   alu_logic u_logic
   (
      .req  (req),
      .lout (lout)
   );

   alu_shifter u_shifter
   (
      .req  (req),
      .sout (sout)
   );

   alu_bitcount u_bitcount
   (
      .req   (req),
      .count (count)
   );

   // owns the output registers
   alu_result u_result
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .enable       (enable),
      .valid        (valid),
      .req          (req),
      .sum          (sum),
      .lout         (lout),
      .sout         (sout),
      .flags        (flags),
      .count        (count),
      .result_ff    (result_ff),
      .result_valid (result_valid)
   );

endmodule

// ==== tb.f ====
src/alu_pkg.sv
src/alu_adder.sv
src/alu_logic.sv
src/alu_shifter.sv
src/alu_bitcount.sv
src/alu_result.sv
src/alu_top.sv
verification/alu_tb.sv

// ==== verification/alu_stimulus.txt ====
# columns: enable valid opcode a b expected_result_ff, all hex
# opcodes: 00 add 01 sub 02 sh1add 03 sh2add 04 sh3add 05 slt 06 sltu 07 and 08 or 09 xor
# 0a andn 0b orn 0c xnor 0d sll 0e srl 0f sra 10 rol 11 ror 12 bext 13 clz 14 ctz 15 cpop
# 16 min 17 max 18 minu 19 maxu 1a sext_b 1b sext_h
1 1 00 00000005 00000003 00000008
1 1 00 7fffffff 00000001 80000000
1 1 01 00000003 00000005 fffffffe
1 1 02 00000010 00000001 00000021
1 1 03 00000010 00000001 00000041
1 1 04 80000001 00000002 0000000a
1 1 05 80000000 00000001 00000001
1 1 05 7fffffff ffffffff 00000000
1 1 06 00000001 ffffffff 00000001
1 1 05 12345678 12345678 00000000
1 1 07 f0f0f0f0 ff00ff00 f000f000
1 1 08 f0f0f0f0 0f0f0000 fffff0f0
1 1 09 aaaaaaaa ffff0000 5555aaaa
1 1 0a f0f0f0f0 ff00ff00 00f000f0
1 1 0b 00000000 ffff0000 0000ffff
1 1 0c 12345678 12345678 ffffffff
1 1 0d 00000001 0000001f 80000000
1 1 0d 12345678 ffffffe0 12345678
1 1 0e 80000000 ffffffe1 40000000
1 1 0f 80000000 0000001f ffffffff
1 1 10 80000001 00000001 00000003
1 1 11 00000001 00000001 80000000
1 1 12 00000100 ffffffe8 00000001
1 1 13 00000000 00000000 00000020
1 1 14 ffffffff 00000000 00000000
1 1 15 ffffffff 00000000 00000020
1 1 15 f0f00001 00000000 00000009
1 1 16 ffffffff 00000001 ffffffff
1 1 17 ffffffff 00000001 00000001
1 1 18 ffffffff 00000001 00000001
1 1 19 ffffffff 00000001 ffffffff
1 1 1a 00000080 00000000 ffffff80
1 1 1b ffff7fff 00000000 00007fff
# back-pressure, result_ff holds the last loaded value
0 1 00 00000001 00000001 00007fff
1 0 00 00000002 00000002 00007fff
0 1 01 00000005 00000003 00007fff
1 1 00 00000002 00000002 00000004

// ==== verification/alu_tb.sv ====
//####################################################################
// run from the project root, vectors come from the stimulus file
// a short LCG burst at the end covers add, xor and sll back to back
//####################################################################
`timescale 1ns/100ps

module alu_tb;

   localparam int PERIOD    = 40;
   localparam int RST_CYC   = 16;
   localparam int LCG_COUNT = 9;

   logic               clk;
   logic               rst_n;
   logic               enable;
   logic               valid;
   alu_pkg::alu_req_t  req;
   alu_pkg::alu_data_t result_ff;
   logic               result_valid;

   // vector store, ctrl is {enable, valid}
   logic [1:0]         vec_ctrl[$];
   alu_pkg::alu_req_t  vec_req[$];
   alu_pkg::alu_data_t vec_exp[$];
   logic               loaded;
   logic               exp_valid;

   alu_top dut0
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .enable       (enable),
      .valid        (valid),
      .req          (req),
      .result_ff    (result_ff),
      .result_valid (result_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // reference for the ops used by the random burst
   function automatic alu_pkg::alu_data_t expected_result(input alu_pkg::alu_req_t r);
      case (r.op)
         alu_pkg::ADD: return r.a + r.b;
         alu_pkg::XOR: return r.a ^ r.b;
         default:      return r.a << r.b[alu_pkg::SHAMT_W-1:0];
      endcase
   endfunction

   task automatic stop_with_failure();
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped after a failure");
   endtask

   task automatic check_outputs(input alu_pkg::alu_data_t exp_data, input logic exp_vld);
      assert (result_valid === exp_vld)
      else
      begin
         $display("[ERROR] result_valid expected %h got %h", exp_vld, result_valid);
         stop_with_failure();
      end
      assert (result_ff === exp_data)
      else
      begin
         $display("[ERROR] result_ff expected %h got %h", exp_data, result_ff);
         stop_with_failure();
      end
   endtask

   task automatic load_vectors();
      int                fd;
      int                n;
      string             line;
      logic [31:0]       fields[6];
      logic [31:0]       state;
      alu_pkg::alu_req_t r;
      fd = $fopen("verification/alu_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the stimulus file");
         stop_with_failure();
      end
      else
      begin
         while ($fgets(line, fd) != 0)
         begin
            if (line.len() > 1 && line.getc(0) != "#")
            begin
               n = $sscanf(line, "%h %h %h %h %h %h", fields[0], fields[1], fields[2],
                           fields[3], fields[4], fields[5]);
               if (n == 6)
               begin
                  vec_ctrl.push_back({fields[0][0], fields[1][0]});
                  vec_req.push_back('{op: alu_pkg::alu_op_e'(fields[2][4:0]),
                                      a: fields[3], b: fields[4]});
                  vec_exp.push_back(fields[5]);
               end
            end
         end
         $fclose(fd);
      end
      // random operand pairs, one request per cycle
      state = 32'd55;
      for (int i = 0; i < LCG_COUNT; i++)
      begin
         state = lcg_next(state);
         r.a = state;
         state = lcg_next(state);
         r.b = state;
         case (i % 3)
            0:       r.op = alu_pkg::ADD;
            1:       r.op = alu_pkg::XOR;
            default: r.op = alu_pkg::SLL;
         endcase
         vec_ctrl.push_back(2'b11);
         vec_req.push_back(r);
         vec_exp.push_back(expected_result(r));
      end
   endtask

   initial
   begin
      enable      = 1'b0;
      valid       = 1'b0;
      req         = '0;
      rst_n       = 1'b0;
      loaded      = 1'b0;
      exp_valid   = 1'b0;
      load_vectors();
      loaded = 1'b1;
      repeat (RST_CYC) @(negedge clk);
      rst_n = 1'b1;
      // idle after reset, nothing taken yet
      @(posedge clk);
      #(PERIOD/2 - 2);
      check_outputs('0, 1'b0);
      foreach (vec_exp[i])
      begin
         @(negedge clk);
         enable = vec_ctrl[i][1];
         valid  = vec_ctrl[i][0];
         req    = vec_req[i];
         // valid register only moves when enable is high
         if (vec_ctrl[i][1])
         begin
            exp_valid = vec_ctrl[i][0];
         end
         @(posedge clk);
         #(PERIOD/2 - 2);
         check_outputs(vec_exp[i], exp_valid);
      end
      @(negedge clk);
      $display("NO ERRORS");
      $finish;
   end

   // watchdog
   initial
   begin
      wait (loaded);
      #((vec_exp.size() + 32) * PERIOD);
      $display("timeout, the run did not finish within %0d cycles", vec_exp.size() + 32);
      stop_with_failure();
   end

endmodule
